//--- rtl/mipsPkg.sv
`default_nettype none

package mipsPkg;

	//////////////////////////////////////////////////
	// Basic field types
	//////////////////////////////////////////////////
	typedef logic [31:0] wordT;
	typedef logic [4:0]  regIdxT;

	// Primary opcode, bits 31:26
	typedef enum logic [5:0] {
		OP_RTYPE = 6'h00,
		OP_BEQ   = 6'h04,
		OP_BNE   = 6'h05,
		OP_ADDIU = 6'h09,
		OP_ANDI  = 6'h0c,
		OP_ORI   = 6'h0d,
		OP_LUI   = 6'h0f,
		OP_LW    = 6'h23,
		OP_SW    = 6'h2b
	} opcodeT;

	// Function field of R-type, bits 5:0
	typedef enum logic [5:0] {
		FN_SLL  = 6'h00, // nop is sll $0,$0,0
		FN_ADDU = 6'h21,
		FN_SUBU = 6'h23,
		FN_AND  = 6'h24,
		FN_OR   = 6'h25,
		FN_SLT  = 6'h2a
	} functT;

	// Field LSB positions
	localparam int OPC_LSB = 26;
	localparam int RS_LSB  = 21;
	localparam int RT_LSB  = 16;
	localparam int RD_LSB  = 11;
	localparam int SH_LSB  = 6;
	localparam int IMM_LSB = 0;

endpackage

`default_nettype wire

//--- rtl/pipePkg.sv
`default_nettype none

package pipePkg;

	// ALU function select
	typedef enum logic [2:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_SLT,
		ALU_SLL,
		ALU_LUI
	} aluOpT;

	typedef struct packed {
		aluOpT aluOp;
		logic  useImm;   // B operand from immediate
		logic  zeroExt;  // andi/ori style immediate
		logic  isBranch;
	} exCtrlT;

	typedef struct packed {
		logic memRead;
		logic memWrite;
		logic branchNe;  // bne rather than beq
	} memCtrlT;

	typedef struct packed {
		logic regWrite;
		logic memToReg;
	} wbCtrlT;

	// Store here goes out through the result port
	localparam logic [31:0] IO_ADDR = 32'hFFFF_FFFC;

endpackage

`default_nettype wire

//--- rtl/stageBuses.sv
`timescale 1ns/10ps
`default_nettype none

//////////////////////////////////////////////////
// ID/EX pipeline register contents
//////////////////////////////////////////////////
interface decExBus
	import mipsPkg::*, pipePkg::*;
();
	logic    valid;
	exCtrlT  exCtrl;
	memCtrlT memCtrl;
	wbCtrlT  wbCtrl;
	wordT    pc4;     // Address after this instruction
	wordT    regA;
	wordT    regB;
	wordT    imm;     // Sign extended imm16
	regIdxT  rs;
	regIdxT  rt;
	regIdxT  destReg;

	modport producer (output valid, exCtrl, memCtrl, wbCtrl, pc4, regA, regB, imm,
		rs, rt, destReg);
	modport consumer (input valid, exCtrl, memCtrl, wbCtrl, pc4, regA, regB, imm,
		rs, rt, destReg);
endinterface

//////////////////////////////////////////////////
// EX/MEM pipeline register contents
//////////////////////////////////////////////////
interface exMemBus
	import mipsPkg::*, pipePkg::*;
();
	logic    valid;
	memCtrlT memCtrl;
	wbCtrlT  wbCtrl;
	wordT    aluResult;   // Also the memory address
	wordT    storeData;
	regIdxT  destReg;
	wordT    branchTarget;
	logic    zero;

	modport producer (output valid, memCtrl, wbCtrl, aluResult, storeData, destReg,
		branchTarget, zero);
	modport consumer (input valid, memCtrl, wbCtrl, aluResult, storeData, destReg,
		branchTarget, zero);
endinterface

`default_nettype wire

//--- rtl/instructionFetch.sv
`timescale 1ns/10ps
`default_nettype none

module instructionFetch
	import mipsPkg::*;
#(
	parameter int imemWords = 256
) (
	input  logic       clk,
	input  logic       rstN,
	input  logic       run,
	input  logic       imemWe,
	input  logic [7:0] imemAddr,
	input  wordT       imemData,
	input  logic       takeBranch,
	input  wordT       branchTarget,
	input  logic       loadStall,
	input  logic       portBusy,
	output wordT       instr,
	output wordT       pc4,
	output logic       fetchValid
);
	localparam int idxW = $clog2(imemWords);

	wordT imem [imemWords];
	wordT pc;
	logic advance; // Fetch a new instruction this cycle

	assign advance = !portBusy && !takeBranch && !loadStall && run;

	// Program load port, only while stopped
	always_ff @(posedge clk) begin
		if (imemWe && !run) begin
			imem[imemAddr[idxW-1:0]] <= imemData;
		end
	end

	always_ff @(posedge clk) begin
		if (!rstN) begin
			pc         <= '0;
			fetchValid <= 1'b0;
		end else if (!portBusy) begin
			if (takeBranch) begin
				pc         <= branchTarget; // Redirect, slot becomes bubble
				fetchValid <= 1'b0;
			end else if (run && !loadStall) begin
				pc         <= pc + 32'd4;
				fetchValid <= 1'b1;
			end else if (!run) begin
				fetchValid <= 1'b0;
			end
		end
	end

	// IF/ID payload
	always_ff @(posedge clk) begin
		if (advance) begin
			instr <= imem[pc[idxW+1:2]];
			pc4   <= pc + 32'd4;
		end
	end

	pcAligned: assert property (@(posedge clk) disable iff (!rstN) pc[1:0] == 2'b00);

endmodule

`default_nettype wire

//--- rtl/instructionDecode.sv
`timescale 1ns/10ps
`default_nettype none

module instructionDecode
	import mipsPkg::*, pipePkg::*;
(
	input  logic    clk,
	input  logic    rstN,
	input  wordT    instr,
	input  wordT    pc4,
	input  logic    fetchValid,
	input  logic    takeBranch,
	input  logic    portBusy,
	input  logic    wbWrite,
	input  regIdxT  wbReg,
	input  wordT    wbData,
	output logic    loadStall,
	decExBus.producer decEx
);
	opcodeT  opcode;
	functT   funct;
	regIdxT  rs, rt, rd, dest;
	exCtrlT  exCtrl;
	memCtrlT memCtrl;
	wbCtrlT  wbCtrl;
	wordT    regs [32];
	wordT    rdA, rdB;

	assign opcode = opcodeT'(instr[OPC_LSB +: 6]);
	assign funct  = functT'(instr[5:0]);
	assign rs     = instr[RS_LSB +: 5];
	assign rt     = instr[RT_LSB +: 5];
	assign rd     = instr[RD_LSB +: 5];

	//////////////////////////////////////////////////
	// Control decode
	//////////////////////////////////////////////////
	always_comb begin
		exCtrl  = '0;
		memCtrl = '0;
		wbCtrl  = '0;
		dest    = rt; // I-type default
		case (opcode)
			OP_RTYPE: begin
				dest            = rd;
				wbCtrl.regWrite = 1'b1;
				case (funct)
					FN_ADDU: exCtrl.aluOp = ALU_ADD;
					FN_SUBU: exCtrl.aluOp = ALU_SUB;
					FN_AND:  exCtrl.aluOp = ALU_AND;
					FN_OR:   exCtrl.aluOp = ALU_OR;
					FN_SLT:  exCtrl.aluOp = ALU_SLT;
					FN_SLL:  exCtrl.aluOp = ALU_SLL;
					default: wbCtrl.regWrite = 1'b0; // Unsupported, acts as nop
				endcase
			end
			OP_ADDIU: begin
				exCtrl.useImm   = 1'b1;
				wbCtrl.regWrite = 1'b1;
			end
			OP_ANDI, OP_ORI: begin
				exCtrl.aluOp    = (opcode == OP_ANDI) ? ALU_AND : ALU_OR;
				exCtrl.useImm   = 1'b1;
				exCtrl.zeroExt  = 1'b1;
				wbCtrl.regWrite = 1'b1;
			end
			OP_LUI: begin
				exCtrl.aluOp    = ALU_LUI;
				exCtrl.useImm   = 1'b1;
				wbCtrl.regWrite = 1'b1;
			end
			OP_LW: begin
				exCtrl.useImm   = 1'b1;
				memCtrl.memRead = 1'b1;
				wbCtrl          = '{regWrite: 1'b1, memToReg: 1'b1};
			end
			OP_SW: begin
				exCtrl.useImm    = 1'b1;
				memCtrl.memWrite = 1'b1;
			end
			OP_BEQ, OP_BNE: begin
				exCtrl.aluOp     = ALU_SUB; // Zero flag compares
				exCtrl.isBranch  = 1'b1;
				memCtrl.branchNe = (opcode == OP_BNE);
			end
			default: ;
		endcase
		if (dest == '0) wbCtrl.regWrite = 1'b0; // $0 stays zero
	end

	// Load in EX feeding this instruction
	assign loadStall = fetchValid && decEx.valid && decEx.memCtrl.memRead &&
		(decEx.destReg == rs || decEx.destReg == rt);

	//////////////////////////////////////////////////
	// Register file, write-through read
	//////////////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (!rstN) begin
			for (int i = 0; i < 32; i++) regs[i] <= '0;
		end else if (wbWrite && wbReg != '0) begin
			regs[wbReg] <= wbData;
		end
	end

	assign rdA = (rs == '0) ? '0 : (wbWrite && wbReg == rs) ? wbData : regs[rs];
	assign rdB = (rt == '0) ? '0 : (wbWrite && wbReg == rt) ? wbData : regs[rt];

	// ID/EX register
	always_ff @(posedge clk) begin
		if (!rstN) begin
			decEx.valid   <= 1'b0;
			decEx.exCtrl  <= '0;
			decEx.memCtrl <= '0;
			decEx.wbCtrl  <= '0;
		end else if (!portBusy) begin
			decEx.valid   <= fetchValid && !takeBranch && !loadStall; // Bubble on flush or stall
			decEx.exCtrl  <= exCtrl;
			decEx.memCtrl <= memCtrl;
			decEx.wbCtrl  <= wbCtrl;
			decEx.pc4     <= pc4;
			decEx.regA    <= rdA;
			decEx.regB    <= rdB;
			decEx.imm     <= {{16{instr[15]}}, instr[IMM_LSB +: 16]};
			decEx.rs      <= rs;
			decEx.rt      <= rt;
			decEx.destReg <= dest;
		end
	end

	noZeroWrite: assert property (@(posedge clk) disable iff (!rstN)
		wbWrite |-> wbReg != '0);

endmodule

`default_nettype wire

//--- rtl/execute.sv
`timescale 1ns/10ps
`default_nettype none

module execute
	import mipsPkg::*, pipePkg::*;
(
	input  logic    clk,
	input  logic    rstN,
	input  logic    portBusy,
	decExBus.consumer decEx,
	input  logic    wbWrite,
	input  regIdxT  wbReg,
	input  wordT    wbData,
	exMemBus.producer exMem,
	output logic    takeBranch,
	output wordT    branchTarget
);
	wordT fwdA, fwdB, immVal, opB, aluOut;
	logic exFwdOk; // EX/MEM result usable now
	logic zero;

	assign exFwdOk = exMem.valid && exMem.wbCtrl.regWrite && !exMem.memCtrl.memRead;

	//////////////////////////////////////////////////
	// Forwarding, EX/MEM before write back
	//////////////////////////////////////////////////
	always_comb begin
		fwdA = decEx.regA;
		fwdB = decEx.regB;
		if (exFwdOk && exMem.destReg == decEx.rs) fwdA = exMem.aluResult;
		else if (wbWrite && wbReg == decEx.rs) fwdA = wbData;
		if (exFwdOk && exMem.destReg == decEx.rt) fwdB = exMem.aluResult;
		else if (wbWrite && wbReg == decEx.rt) fwdB = wbData;
	end

	assign immVal = decEx.exCtrl.zeroExt ? {16'h0, decEx.imm[15:0]} : decEx.imm;
	assign opB    = decEx.exCtrl.useImm ? immVal : fwdB;

	always_comb begin
		case (decEx.exCtrl.aluOp)
			ALU_ADD: aluOut = fwdA + opB;
			ALU_SUB: aluOut = fwdA - opB;
			ALU_AND: aluOut = fwdA & opB;
			ALU_OR:  aluOut = fwdA | opB;
			ALU_SLT: aluOut = {31'h0, $signed(fwdA) < $signed(opB)};
			ALU_SLL: aluOut = opB << decEx.imm[SH_LSB +: 5]; // shamt inside imm16
			ALU_LUI: aluOut = {opB[15:0], 16'h0};
			default: aluOut = '0;
		endcase
	end

	// Branch resolves here
	assign zero         = (aluOut == '0);
	assign branchTarget = decEx.pc4 + {decEx.imm[29:0], 2'b00};
	assign takeBranch   = decEx.valid && decEx.exCtrl.isBranch && !portBusy &&
		(zero ^ decEx.memCtrl.branchNe);

	// EX/MEM register
	always_ff @(posedge clk) begin
		if (!rstN) begin
			exMem.valid   <= 1'b0;
			exMem.memCtrl <= '0;
			exMem.wbCtrl  <= '0;
		end else if (!portBusy) begin
			exMem.valid        <= decEx.valid;
			exMem.memCtrl      <= decEx.memCtrl;
			exMem.wbCtrl       <= decEx.wbCtrl;
			exMem.aluResult    <= aluOut;
			exMem.storeData    <= fwdB;     // Forwarded rt for sw
			exMem.destReg      <= decEx.destReg;
			exMem.branchTarget <= branchTarget;
			exMem.zero         <= zero;
		end
	end

	// Slot behind a taken branch is always a bubble
	flushAfterBranch: assert property (@(posedge clk) disable iff (!rstN)
		takeBranch |=> !decEx.valid);

endmodule

`default_nettype wire

//--- rtl/memoryAccess.sv
`timescale 1ns/10ps
`default_nettype none

module memoryAccess
	import mipsPkg::*, pipePkg::*;
#(
	parameter int dmemWords = 256
) (
	input  logic    clk,
	input  logic    rstN,
	input  logic    portBusy,
	exMemBus.consumer exMem,
	output logic    wbWrite,
	output regIdxT  wbReg,
	output wordT    wbData,
	output logic    ioReq,
	output wordT    ioData
);
	localparam int idxW = $clog2(dmemWords);

	wordT dmem [dmemWords];
	logic isIo;
	logic ioSent;     // Request already raised for the held store
	wordT loadQ, aluQ;
	logic memToRegQ;

	assign isIo   = exMem.aluResult == IO_ADDR;
	assign ioReq  = exMem.valid && exMem.memCtrl.memWrite && isIo && !ioSent;
	assign ioData = exMem.storeData;

	always_ff @(posedge clk) begin
		if (!rstN) ioSent <= 1'b0;
		else       ioSent <= portBusy && (ioSent || ioReq); // Clears as pipe moves
	end

	// Data memory without the I/O word
	always_ff @(posedge clk) begin
		if (exMem.valid && exMem.memCtrl.memWrite && !isIo && !portBusy) begin
			dmem[exMem.aluResult[idxW+1:2]] <= exMem.storeData;
		end
	end

	//////////////////////////////////////////////////
	// MEM/WB register and write-back select
	//////////////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (!rstN) begin
			wbWrite <= 1'b0;
		end else if (!portBusy) begin
			wbWrite   <= exMem.valid && exMem.wbCtrl.regWrite;
			wbReg     <= exMem.destReg;
			memToRegQ <= exMem.wbCtrl.memToReg;
			loadQ     <= dmem[exMem.aluResult[idxW+1:2]];
			aluQ      <= exMem.aluResult;
		end
	end

	assign wbData = memToRegQ ? loadQ : aluQ;

endmodule

`default_nettype wire

//--- rtl/resultPort.sv
`timescale 1ns/10ps
`default_nettype none

module resultPort
	import mipsPkg::*;
(
	input  logic clk,
	input  logic rstN,
	input  logic ioReq,
	input  wordT ioData,
	input  logic outAck,
	output logic outReq,
	output wordT outData,
	output logic portBusy
);
	typedef enum logic [1:0] {IDLE, REQUEST, RELEASE, WAIT_ACK_LOW} stateT;
	stateT state;

	always_ff @(posedge clk) begin
		if (!rstN) begin
			state <= IDLE;
		end else begin
			case (state)
				IDLE:         if (ioReq) state <= REQUEST;
				REQUEST:      if (outAck) state <= RELEASE;   // Ack seen so req drops
				RELEASE:      state <= outAck ? WAIT_ACK_LOW : IDLE;
				WAIT_ACK_LOW: if (!outAck) state <= IDLE;
				default:      state <= IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == IDLE && ioReq) outData <= ioData; // Latched once per store
	end

	assign outReq   = (state == REQUEST);
	assign portBusy = ioReq || (state != IDLE);

	// Environment acks only a pending request
	ackNeedsReq: assert property (@(posedge clk) disable iff (!rstN)
		$rose(outAck) |-> outReq);
	// Memory stage offers a store only while idle
	ioReqOnlyIdle: assert property (@(posedge clk) disable iff (!rstN)
		ioReq |-> state == IDLE);

endmodule

`default_nettype wire

//--- rtl/mipsCore.sv
`timescale 1ns/10ps
`default_nettype none

module mipsCore
	import mipsPkg::*;
#(
	parameter int imemWords = 256,
	parameter int dmemWords = 256
) (
	input  logic       clk,
	input  logic       rstN,
	input  logic       run,
	input  logic       imemWe,
	input  logic [7:0] imemAddr,
	input  wordT       imemData,
	input  logic       outAck,
	output logic       outReq,
	output wordT       outData
);
	//////////////////////////////////////////////////
	// Stage to stage nets
	//////////////////////////////////////////////////
	wordT   instr, pc4;        // IF/ID
	logic   fetchValid;
	logic   takeBranch;        // Redirect from EX
	wordT   branchTarget;
	logic   loadStall;
	logic   portBusy;          // Freezes every stage
	logic   wbWrite;           // Write back to regfile and forwarding
	regIdxT wbReg;
	wordT   wbData;
	logic   ioReq;
	wordT   ioData;

	decExBus decEx ();
	exMemBus exMem ();

	instructionFetch #(.imemWords(imemWords)) i_instructionFetch (
		.clk, .rstN, .run, .imemWe, .imemAddr, .imemData,
		.takeBranch, .branchTarget, .loadStall, .portBusy,
		.instr, .pc4, .fetchValid
	);

	instructionDecode i_instructionDecode (
		.clk, .rstN, .instr, .pc4, .fetchValid, .takeBranch, .portBusy,
		.wbWrite, .wbReg, .wbData, .loadStall,
		.decEx (decEx.producer)
	);

	execute i_execute (
		.clk, .rstN, .portBusy,
		.decEx (decEx.consumer),
		.wbWrite, .wbReg, .wbData,
		.exMem (exMem.producer),
		.takeBranch, .branchTarget
	);

	memoryAccess #(.dmemWords(dmemWords)) i_memoryAccess (
		.clk, .rstN, .portBusy,
		.exMem (exMem.consumer),
		.wbWrite, .wbReg, .wbData, .ioReq, .ioData
	);

	resultPort i_resultPort (
		.clk, .rstN, .ioReq, .ioData, .outAck, .outReq, .outData, .portBusy
	);

endmodule

`default_nettype wire

//--- tests/clockGen.sv
`timescale 1ns/10ps
`default_nettype none

module clockGen #(
	parameter int halfPeriod  = 4,  // ns, 8 ns period
	parameter int resetCycles = 3
) (
	output logic clk,
	output logic rstN
);
	initial begin
		clk = 1'b0;
		forever #(halfPeriod) clk = ~clk;
	end

	// Released on a falling edge, after resetCycles rising edges
	initial begin
		rstN = 1'b0;
		repeat (resetCycles) @(negedge clk);
		rstN = 1'b1;
	end

endmodule

`default_nettype wire

//--- tests/mipsCoreTb.sv
`timescale 1ns/10ps
`default_nettype none

module mipsCoreTb
	import mipsPkg::*;
();
	localparam int outputTimeout  = 600; // Cycles a test may wait for its words
	localparam int settleCycles   = 24;  // Quiet time, catches late or extra words
	localparam int progWordsBound = 100; // All programs, parking loops included
	localparam int worstHandshake = 20;  // Two ack delays of 7 plus FSM turnaround
	localparam int watchdogCycles = progWordsBound * worstHandshake * 4;

	logic       clk, genRstN, restartN, coreRstN;
	logic       run, imemWe, outAck, outReq;
	logic [7:0] imemAddr;
	wordT       imemData, outData;

	wordT        prog [$];       // Program being built
	wordT        gotQ [$];       // Words seen on outData, in order
	int unsigned ackDelays [64]; // Drawn once from the seeded generator
	int          delayIdx    = 0;
	int          errorCount  = 0;
	int          testCount   = 0;
	int          failedTests = 0;

	clockGen #(.halfPeriod(4), .resetCycles(3)) i_clockGen (.clk, .rstN(genRstN));

	assign coreRstN = genRstN && restartN; // Power-up reset or per-test restart

	mipsCore #(.imemWords(256), .dmemWords(256)) i_mipsCore (
		.clk, .rstN(coreRstN), .run, .imemWe, .imemAddr, .imemData,
		.outAck, .outReq, .outData
	);

	//////////////////////////////////////////////////
	// Instruction encoding
	//////////////////////////////////////////////////
	function automatic wordT rType(functT fn, int rd, int rs, int rt, int sh);
		return {OP_RTYPE, 5'(rs), 5'(rt), 5'(rd), 5'(sh), fn};
	endfunction

	function automatic wordT iType(opcodeT op, int rt, int rs, logic [15:0] imm);
		return {op, 5'(rs), 5'(rt), imm};
	endfunction

	function automatic wordT ioStore(int rt);
		return iType(OP_SW, rt, 0, 16'hFFFC); // -4($0) is the I/O word
	endfunction

	//////////////////////////////////////////////////
	// Program load and run control
	//////////////////////////////////////////////////
	task automatic loadProgram();
		@(negedge clk);
		run      = 1'b0;
		restartN = 1'b0; // Core held in reset while loading
		prog.push_back(iType(OP_BEQ, 0, 0, 16'hFFFF)); // Parking loop
		prog.push_back('0);                            // Its flushed slot
		foreach (prog[i]) begin
			imemWe   = 1'b1;
			imemAddr = 8'(i);
			imemData = prog[i];
			@(negedge clk);
		end
		imemWe   = 1'b0;
		restartN = 1'b1;
	endtask

	task automatic startProgram();
		loadProgram();
		gotQ.delete();
		run = 1'b1;
	endtask

	// Waits for the expected count, then stays quiet for a while
	task automatic checkOutputs(input wordT expQ [$]);
		int waited;
		waited = 0;
		while (gotQ.size() < expQ.size() && waited < outputTimeout) begin
			@(negedge clk);
			waited++;
		end
		repeat (settleCycles) @(negedge clk);
		if (gotQ.size() != expQ.size()) begin
			$display("Wrong number of words on outData: expected %0d, received %0d",
				expQ.size(), gotQ.size());
			errorCount++;
		end
		foreach (expQ[i]) begin
			if (i < gotQ.size() && gotQ[i] !== expQ[i]) begin
				$display("CHECK FAILED outData[%0d] expected 0x%08h got 0x%08h",
					i, expQ[i], gotQ[i]);
				errorCount++;
			end
		end
	endtask

	task automatic reportTest(input string name, input int errsBefore);
		testCount++;
		if (errorCount == errsBefore) begin
			$display("test %-20s ok", name);
		end else begin
			failedTests++;
			$display("test %-20s %0d errors", name, errorCount - errsBefore);
		end
	endtask

	//////////////////////////////////////////////////
	// Directed tests
	//////////////////////////////////////////////////
	task automatic resetTest();
		wordT noneQ [$];
		int   errsBefore;
		errsBefore = errorCount;
		prog.delete();
		prog.push_back(iType(OP_ADDIU, 1, 0, 16'h0099));
		prog.push_back(ioStore(1));
		loadProgram();
		gotQ.delete();
		repeat (40) begin // Run stays low, nothing may leave
			@(negedge clk);
			if (outReq !== 1'b0) begin
				$display("CHECK FAILED outReq expected 0x0 got 0x%0h", outReq);
				errorCount++;
			end
		end
		checkOutputs(noneQ);
		reportTest("reset and idle", errsBefore);
	endtask

	task automatic aluTest();
		wordT r [16];
		wordT expQ [$];
		int   errsBefore;
		errsBefore = errorCount;
		prog.delete();
		prog.push_back(iType(OP_LUI, 1, 0, 16'h8000));
		prog.push_back(ioStore(1));
		prog.push_back(iType(OP_ORI, 1, 1, 16'h1234));
		prog.push_back(ioStore(1));
		prog.push_back(iType(OP_ADDIU, 2, 0, 16'hFFFB));
		prog.push_back(ioStore(2));
		prog.push_back(rType(FN_ADDU, 3, 1, 2, 0));
		prog.push_back(ioStore(3));
		prog.push_back(rType(FN_SUBU, 4, 3, 2, 0));
		prog.push_back(ioStore(4));
		prog.push_back(rType(FN_AND, 5, 3, 2, 0));
		prog.push_back(ioStore(5));
		prog.push_back(rType(FN_OR, 6, 1, 2, 0));
		prog.push_back(ioStore(6));
		prog.push_back(rType(FN_SLT, 7, 1, 2, 0));
		prog.push_back(ioStore(7));
		prog.push_back(rType(FN_SLL, 8, 0, 3, 4));
		prog.push_back(ioStore(8));
		prog.push_back(iType(OP_ANDI, 9, 2, 16'hF0F0));
		prog.push_back(ioStore(9));
		prog.push_back(iType(OP_ADDIU, 10, 8, 16'h0001));
		prog.push_back(rType(FN_ADDU, 10, 10, 10, 0)); // Both operands from EX/MEM
		prog.push_back(ioStore(10));
		startProgram();
		// Reference values, straight from the ISA rules
		r[1] = {16'h8000, 16'h0000};
		expQ.push_back(r[1]);
		r[1] = r[1] | {16'h0000, 16'h1234}; // ori zero-extends
		expQ.push_back(r[1]);
		r[2] = {{16{1'b1}}, 16'hFFFB};      // addiu sign-extends
		expQ.push_back(r[2]);
		r[3] = r[1] + r[2];
		expQ.push_back(r[3]);
		r[4] = r[3] - r[2];
		expQ.push_back(r[4]);
		r[5] = r[3] & r[2];
		expQ.push_back(r[5]);
		r[6] = r[1] | r[2];
		expQ.push_back(r[6]);
		r[7] = ($signed(r[1]) < $signed(r[2])) ? 32'd1 : 32'd0;
		expQ.push_back(r[7]);
		r[8] = r[3] << 4;
		expQ.push_back(r[8]);
		r[9] = r[2] & {16'h0000, 16'hF0F0};
		expQ.push_back(r[9]);
		r[10] = r[8] + 32'd1;
		r[10] = r[10] + r[10];
		expQ.push_back(r[10]);
		checkOutputs(expQ);
		reportTest("alu and forwarding", errsBefore);
	endtask

	task automatic memoryTest();
		wordT r [16];
		wordT mem [8]; // Word index = byte address / 4
		wordT expQ [$];
		int   errsBefore;
		errsBefore = errorCount;
		prog.delete();
		prog.push_back(iType(OP_ADDIU, 1, 0, 16'h0055));
		prog.push_back(iType(OP_LUI, 2, 0, 16'h1234));
		prog.push_back(iType(OP_ORI, 2, 2, 16'h5678));
		prog.push_back(iType(OP_SW, 2, 0, 16'h0008));
		prog.push_back(iType(OP_SW, 1, 0, 16'h000C));
		prog.push_back(iType(OP_LW, 3, 0, 16'h0008));
		prog.push_back(rType(FN_ADDU, 4, 3, 1, 0)); // Load-use on rs
		prog.push_back(ioStore(4));
		prog.push_back(iType(OP_LW, 5, 0, 16'h000C));
		prog.push_back(ioStore(5));                 // Load-use on store data
		prog.push_back(iType(OP_LW, 6, 0, 16'h0008));
		prog.push_back(iType(OP_SW, 6, 0, 16'h0010));
		prog.push_back(iType(OP_LW, 7, 0, 16'h0010));
		prog.push_back(rType(FN_SUBU, 8, 7, 1, 0));
		prog.push_back(ioStore(8));
		startProgram();
		r[1]   = 32'h0000_0055;
		r[2]   = {16'h1234, 16'h5678};
		mem[2] = r[2];
		mem[3] = r[1];
		expQ.push_back(mem[2] + r[1]);
		expQ.push_back(mem[3]);
		mem[4] = mem[2];
		expQ.push_back(mem[4] - r[1]);
		checkOutputs(expQ);
		reportTest("memory and load-use", errsBefore);
	endtask

	task automatic branchTest();
		wordT sum, i;
		wordT expQ [$];
		int   errsBefore;
		errsBefore = errorCount;
		prog.delete();
		prog.push_back(iType(OP_ADDIU, 1, 0, 16'h0000)); // 0x00 sum
		prog.push_back(iType(OP_ADDIU, 2, 0, 16'h0001)); // 0x04 counter
		prog.push_back(iType(OP_ADDIU, 3, 0, 16'h000B)); // 0x08 limit
		prog.push_back(rType(FN_ADDU, 1, 1, 2, 0));      // 0x0c loop
		prog.push_back(iType(OP_ADDIU, 2, 2, 16'h0001)); // 0x10
		prog.push_back(iType(OP_BNE, 3, 2, 16'hFFFD));   // 0x14 back to 0x0c
		prog.push_back(ioStore(1));                      // 0x18
		prog.push_back(iType(OP_BEQ, 1, 1, 16'h0002));   // 0x1c taken, to 0x28
		prog.push_back(ioStore(2));                      // 0x20 flushed
		prog.push_back(ioStore(3));                      // 0x24 never fetched
		prog.push_back(iType(OP_BEQ, 2, 1, 16'h0001));   // 0x28 not taken
		prog.push_back(iType(OP_ADDIU, 4, 0, 16'h0077)); // 0x2c
		prog.push_back(ioStore(4));                      // 0x30
		startProgram();
		sum = '0;
		i   = 32'd1;
		do begin
			sum = sum + i;
			i   = i + 32'd1;
		end while (i != 32'd11); // bne back edge
		expQ.push_back(sum);
		if (sum != i) begin // beq falls through to the addiu
			expQ.push_back(32'h0000_0077);
		end
		checkOutputs(expQ);
		reportTest("branches and flush", errsBefore);
	endtask

	task automatic burstTest();
		wordT vals [8];
		wordT expQ [$];
		int   errsBefore;
		errsBefore = errorCount;
		prog.delete();
		foreach (vals[k]) begin
			vals[k] = {16'h0000, 16'($urandom)};
		end
		for (int k = 0; k < 8; k++) begin
			prog.push_back(iType(OP_ORI, k + 1, 0, vals[k][15:0]));
		end
		for (int k = 0; k < 8; k++) begin
			prog.push_back(ioStore(k + 1)); // Eight stores back to back
		end
		startProgram();
		foreach (vals[k]) begin
			expQ.push_back(vals[k]);
		end
		checkOutputs(expQ);
		reportTest("back-pressure burst", errsBefore);
	endtask

	//////////////////////////////////////////////////
	// Handshake responder and monitor
	//////////////////////////////////////////////////
	initial begin : handshakeResponder
		int unsigned delay;
		outAck = 1'b0;
		forever begin
			@(negedge clk);
			if (outReq) begin
				gotQ.push_back(outData);
				delay = ackDelays[delayIdx % 64];
				delayIdx++;
				repeat (delay) @(negedge clk);
				outAck = 1'b1;
				do @(negedge clk); while (outReq); // Req must drop after ack
				delay = ackDelays[delayIdx % 64];
				delayIdx++;
				repeat (delay) begin
					@(negedge clk);
					if (outReq) begin
						$display("Handshake error: outReq rose again before outAck fell");
						errorCount++;
					end
				end
				outAck = 1'b0;
			end
		end
	end

	initial begin : watchdog
		repeat (watchdogCycles) @(posedge clk);
		$display("Watchdog expired after %0d cycles, the run did not finish",
			watchdogCycles);
		$display("=== FAIL ===");
		$finish;
	end

	initial begin : mainSequence
		void'($urandom(32'h2ff7_031b));
		foreach (ackDelays[i]) begin
			ackDelays[i] = $urandom % 8; // 0 to 7 cycles
		end
		run      = 1'b0;
		imemWe   = 1'b0;
		imemAddr = '0;
		imemData = '0;
		restartN = 1'b1;
		wait (genRstN === 1'b1);
		resetTest();
		aluTest();
		memoryTest();
		branchTest();
		burstTest();
		$display("%0d tests, %0d failed, %0d errors", testCount, failedTests, errorCount);
		if (errorCount == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- filelist.f
rtl/mipsPkg.sv
rtl/pipePkg.sv
rtl/stageBuses.sv
rtl/instructionFetch.sv
rtl/instructionDecode.sv
rtl/execute.sv
rtl/memoryAccess.sv
rtl/resultPort.sv
rtl/mipsCore.sv
tests/clockGen.sv
tests/mipsCoreTb.sv

//--- Bender.yml
package:
  name: mipsCore

sources:
  # Design, in compile order
  - rtl/mipsPkg.sv
  - rtl/pipePkg.sv
  - rtl/stageBuses.sv
  - rtl/instructionFetch.sv
  - rtl/instructionDecode.sv
  - rtl/execute.sv
  - rtl/memoryAccess.sv
  - rtl/resultPort.sv
  - rtl/mipsCore.sv
  # Testbench
  - target: test
    files:
      - tests/clockGen.sv
      - tests/mipsCoreTb.sv
